//--- Makefile
TOP = plic_tb

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) \
		-f build.f -o $(TOP)_sim
	./obj_dir/$(TOP)_sim

clean:
	rm -rf obj_dir

.PHONY: sim clean

//--- build.f
plic_map_pkg.sv
plic_src_pkg.sv
plic_reg_decode.sv
plic_gateway.sv
plic_register_file.sv
plic_priority_tree.sv
plic_top.sv
plic_properties.sv
plic_tb.sv

//--- plic_gateway.sv
`timescale 1ns/1ps

module plic_gateway #(
    parameter int NUM_SOURCES = plic_src_pkg::NUM_SOURCES_DEF,
    localparam int IDX_W = $clog2(NUM_SOURCES)
) (
    input  logic                   clk,
    input  logic                   rstn,
    input  logic [NUM_SOURCES-1:0] int_src,
    input  logic                   done_pulse,
    input  logic [IDX_W-1:0]       done_id,
    output logic [NUM_SOURCES-1:0] gw_set
);

    plic_src_pkg::gw_state_t gw_state [1:NUM_SOURCES-1];

    always_ff @(posedge clk)
    begin
        if (!rstn)
        begin
            gw_set <= '0;
            for (int n = 1; n < NUM_SOURCES; n++)
                gw_state[n] <= plic_src_pkg::GW_READY;
        end
        else
        begin
            gw_set <= '0;
            for (int n = 1; n < NUM_SOURCES; n++)  // Source 0 never admitted.
            begin
                case (gw_state[n])
                    plic_src_pkg::GW_READY:
                        if (int_src[n])
                        begin
                            gw_set[n]   <= 1'b1;
                            gw_state[n] <= plic_src_pkg::GW_IN_SERVICE;
                        end
                    default:
                        if (done_pulse && done_id == IDX_W'(n))
                            gw_state[n] <= plic_src_pkg::GW_READY;  // Level rechecked next cycle.
                endcase
            end
        end
    end

endmodule

//--- plic_map_pkg.sv
package plic_map_pkg;

    // ------------------------------
    // Host port widths
    // ------------------------------
    parameter int ADDR_WIDTH = 24;
    parameter int DATA_WIDTH = 32;

    // ------------------------------
    // Register map
    // ------------------------------
    parameter logic [ADDR_WIDTH-1:0] PRIO_BASE  = 24'h000000;  // Source n at base + 4n.
    parameter logic [ADDR_WIDTH-1:0] PEND_ADDR  = 24'h001000;  // Read only.
    parameter logic [ADDR_WIDTH-1:0] EN_ADDR    = 24'h002000;
    parameter logic [ADDR_WIDTH-1:0] THR_ADDR   = 24'h200000;
    parameter logic [ADDR_WIDTH-1:0] CLAIM_ADDR = 24'h200004;  // Claim on read, complete on write.

    typedef enum logic [3:0] {
        OP_NONE,
        OP_PRIO_WR,
        OP_PRIO_RD,
        OP_PEND_RD,
        OP_EN_WR,
        OP_EN_RD,
        OP_THR_WR,
        OP_THR_RD,
        OP_CLAIM,
        OP_COMPLETE
    } reg_op_t;

endpackage

//--- plic_priority_tree.sv
`timescale 1ns/1ps

module plic_priority_tree #(
    parameter int NUM_SOURCES = plic_src_pkg::NUM_SOURCES_DEF,
    parameter int PRIO_WIDTH  = plic_src_pkg::PRIO_WIDTH_DEF,
    localparam int IDX_W = $clog2(NUM_SOURCES)
) (
    input  logic                              clk,
    input  logic                              rstn,
    input  logic [NUM_SOURCES*PRIO_WIDTH-1:0] prio_vec,
    input  logic [NUM_SOURCES-1:0]            pending,
    input  logic [NUM_SOURCES-1:0]            enable,
    input  logic [PRIO_WIDTH-1:0]             threshold,
    output logic [IDX_W-1:0]                  winner_id,
    output logic                              notif
);

    localparam int LEAVES = 1 << IDX_W;

    logic [LEAVES-1:0]            live;
    logic [LEAVES*PRIO_WIDTH-1:0] prio_pad;
    logic [PRIO_WIDTH-1:0]        node_prio [1:2*LEAVES-1];
    logic [IDX_W-1:0]             node_id   [1:2*LEAVES-1];

    assign live     = LEAVES'(pending & enable);
    assign prio_pad = (LEAVES*PRIO_WIDTH)'(prio_vec);

    // ------------------------------
    // Tournament tree
    // ------------------------------
    always_comb
    begin
        for (int n = 0; n < LEAVES; n++)
        begin
            node_id[LEAVES+n]   = IDX_W'(n);
            node_prio[LEAVES+n] = live[n] ? prio_pad[n*PRIO_WIDTH +: PRIO_WIDTH] : '0;
        end
        // Left child holds lower IDs, so ties go left.
        for (int i = LEAVES - 1; i >= 1; i--)
        begin
            if (node_prio[2*i] >= node_prio[2*i+1])
            begin
                node_prio[i] = node_prio[2*i];
                node_id[i]   = node_id[2*i];
            end
            else
            begin
                node_prio[i] = node_prio[2*i+1];
                node_id[i]   = node_id[2*i+1];
            end
        end
    end

    assign winner_id = (node_prio[1] > threshold) ? node_id[1] : '0;

    always_ff @(posedge clk)
    begin
        if (!rstn)
            notif <= 1'b0;
        else
            notif <= (winner_id != 0);
    end

endmodule

//--- plic_properties.sv
`timescale 1ns/1ps

module plic_properties (
    input logic clk,
    input logic rstn,
    input logic req,
    input logic ack
);

    // ------------------------------
    // Handshake rules
    // ------------------------------
    ack_needs_req: assert property (
        @(posedge clk) disable iff (!rstn) $rose(ack) |-> $past(req)
    ) else $error("ack rose without a pending req");

    ack_holds_for_req: assert property (
        @(posedge clk) disable iff (!rstn) ack && req |=> ack
    ) else $error("ack dropped while req was still high");

    ack_low_after_reset: assert property (
        @(posedge clk) !rstn |=> !ack
    ) else $error("ack high in the cycle after reset");

endmodule

bind plic_reg_decode plic_properties i_plic_properties (
    .clk(clk), .rstn(rstn), .req(req), .ack(ack)
);

//--- plic_reg_decode.sv
`timescale 1ns/1ps

module plic_reg_decode #(
    parameter int NUM_SOURCES = plic_src_pkg::NUM_SOURCES_DEF,
    localparam int IDX_W = $clog2(NUM_SOURCES)
) (
    input  logic                                clk,
    input  logic                                rstn,
    input  logic                                req,
    input  logic                                wr,
    input  logic [plic_map_pkg::ADDR_WIDTH-1:0] addr,
    input  logic [plic_map_pkg::DATA_WIDTH-1:0] wdata,
    input  logic                                op_done,
    output logic                                ack,
    output logic                                op_valid,
    output plic_map_pkg::reg_op_t               op,
    output logic [IDX_W-1:0]                    idx,
    output logic [plic_map_pkg::DATA_WIDTH-1:0] op_wdata
);

    localparam int AW = plic_map_pkg::ADDR_WIDTH;

    plic_src_pkg::bus_state_t state;
    plic_map_pkg::reg_op_t    dec_op;
    logic [IDX_W-1:0]         dec_idx;
    logic [AW-1:0]            prio_off;
    logic [AW-3:0]            word_idx;

    // ------------------------------
    // Address classification
    // ------------------------------
    always_comb
    begin
        prio_off = addr - plic_map_pkg::PRIO_BASE;
        word_idx = prio_off[AW-1:2];
        dec_op   = plic_map_pkg::OP_NONE;  // Unmapped reads return 0.
        dec_idx  = '0;
        if (addr[1:0] == 2'b00)
        begin
            if (addr < plic_map_pkg::PEND_ADDR)
            begin
                if (word_idx != 0 && word_idx < NUM_SOURCES)
                begin
                    dec_op  = wr ? plic_map_pkg::OP_PRIO_WR : plic_map_pkg::OP_PRIO_RD;
                    dec_idx = word_idx[IDX_W-1:0];
                end
            end
            else if (addr == plic_map_pkg::PEND_ADDR && !wr)
                dec_op = plic_map_pkg::OP_PEND_RD;
            else if (addr == plic_map_pkg::EN_ADDR)
                dec_op = wr ? plic_map_pkg::OP_EN_WR : plic_map_pkg::OP_EN_RD;
            else if (addr == plic_map_pkg::THR_ADDR)
                dec_op = wr ? plic_map_pkg::OP_THR_WR : plic_map_pkg::OP_THR_RD;
            else if (addr == plic_map_pkg::CLAIM_ADDR)
                dec_op = wr ? plic_map_pkg::OP_COMPLETE : plic_map_pkg::OP_CLAIM;
        end
    end

    // ------------------------------
    // Four-phase handshake
    // ------------------------------
    always_ff @(posedge clk)
    begin
        if (!rstn)
        begin
            state    <= plic_src_pkg::BUS_IDLE;
            ack      <= 1'b0;
            op_valid <= 1'b0;
        end
        else
        begin
            op_valid <= 1'b0;
            case (state)
                plic_src_pkg::BUS_IDLE:
                    if (req)
                    begin
                        op_valid <= 1'b1;
                        state    <= plic_src_pkg::BUS_EXEC;
                    end
                plic_src_pkg::BUS_EXEC:
                    if (op_done)
                    begin
                        ack   <= 1'b1;  // Read data already valid.
                        state <= plic_src_pkg::BUS_ACK;
                    end
                plic_src_pkg::BUS_ACK:
                    if (!req)
                    begin
                        ack   <= 1'b0;
                        state <= plic_src_pkg::BUS_IDLE;
                    end
                default:
                    state <= plic_src_pkg::BUS_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (state == plic_src_pkg::BUS_IDLE && req)
        begin
            op       <= dec_op;
            idx      <= dec_idx;
            op_wdata <= wdata;
        end
    end

endmodule

//--- plic_register_file.sv
`timescale 1ns/1ps

module plic_register_file #(
    parameter int NUM_SOURCES = plic_src_pkg::NUM_SOURCES_DEF,
    parameter int PRIO_WIDTH  = plic_src_pkg::PRIO_WIDTH_DEF,
    localparam int IDX_W = $clog2(NUM_SOURCES)
) (
    input  logic                                clk,
    input  logic                                rstn,
    input  logic                                op_valid,
    input  plic_map_pkg::reg_op_t               op,
    input  logic [IDX_W-1:0]                    idx,
    input  logic [plic_map_pkg::DATA_WIDTH-1:0] op_wdata,
    input  logic [NUM_SOURCES-1:0]              gw_set,
    input  logic [IDX_W-1:0]                    winner_id,
    output logic                                op_done,
    output logic [plic_map_pkg::DATA_WIDTH-1:0] rdata,
    output logic                                done_pulse,
    output logic [IDX_W-1:0]                    done_id,
    output logic [NUM_SOURCES*PRIO_WIDTH-1:0]   prio_vec,
    output logic [NUM_SOURCES-1:0]              pending,
    output logic [NUM_SOURCES-1:0]              enable,
    output logic [PRIO_WIDTH-1:0]               threshold
);

    localparam int DW = plic_map_pkg::DATA_WIDTH;
    localparam logic [NUM_SOURCES-1:0] SRC_MASK = {{(NUM_SOURCES-1){1'b1}}, 1'b0};

    logic [NUM_SOURCES-1:0][PRIO_WIDTH-1:0] prio_q;
    logic [NUM_SOURCES-1:0]                 claim_clr;
    logic                                   cpl_ok;
    logic [DW-1:0]                          read_data;

    assign prio_vec = prio_q;

    // ------------------------------
    // Claim and complete
    // ------------------------------
    always_comb
    begin
        claim_clr = '0;
        if (op_valid && op == plic_map_pkg::OP_CLAIM && winner_id != 0)
            claim_clr[winner_id] = 1'b1;
    end

    assign cpl_ok = op_valid && op == plic_map_pkg::OP_COMPLETE
                    && op_wdata != 0 && op_wdata < NUM_SOURCES;

    always_comb
    begin
        case (op)
            plic_map_pkg::OP_PRIO_RD: read_data = DW'(prio_q[idx]);
            plic_map_pkg::OP_PEND_RD: read_data = DW'(pending);
            plic_map_pkg::OP_EN_RD:   read_data = DW'(enable);
            plic_map_pkg::OP_THR_RD:  read_data = DW'(threshold);
            plic_map_pkg::OP_CLAIM:   read_data = DW'(winner_id);
            default:                  read_data = '0;  // Writes and unmapped.
        endcase
    end

    // ------------------------------
    // Register update
    // ------------------------------
    always_ff @(posedge clk)
    begin
        if (!rstn)
        begin
            prio_q     <= '0;
            pending    <= '0;
            enable     <= '0;
            threshold  <= '0;
            op_done    <= 1'b0;
            done_pulse <= 1'b0;
            done_id    <= '0;
            rdata      <= '0;
        end
        else
        begin
            op_done    <= op_valid;
            done_pulse <= cpl_ok;
            pending    <= (pending | gw_set) & ~claim_clr & SRC_MASK;  // Claim beats set.
            if (cpl_ok)
                done_id <= op_wdata[IDX_W-1:0];
            if (op_valid)
            begin
                case (op)
                    plic_map_pkg::OP_PRIO_WR: prio_q[idx] <= op_wdata[PRIO_WIDTH-1:0];
                    plic_map_pkg::OP_EN_WR:   enable <= op_wdata[NUM_SOURCES-1:0] & SRC_MASK;
                    plic_map_pkg::OP_THR_WR:  threshold <= op_wdata[PRIO_WIDTH-1:0];
                    default: ;
                endcase
                rdata <= read_data;
            end
        end
    end

endmodule

//--- plic_src_pkg.sv
package plic_src_pkg;

    // ------------------------------
    // Source defaults
    // ------------------------------
    parameter int NUM_SOURCES_DEF = 32;  // Source 0 reserved.
    parameter int PRIO_WIDTH_DEF  = 3;

    // ------------------------------
    // State encodings
    // ------------------------------
    typedef enum logic [1:0] {
        BUS_IDLE,
        BUS_EXEC,
        BUS_ACK
    } bus_state_t;

    typedef enum logic {
        GW_READY,
        GW_IN_SERVICE
    } gw_state_t;

endpackage

//--- plic_stim.txt
# cmd addr data expect (hex). W write, R read and compare, S set int_src, N compare notif
W 000004 0000000F 00000000
R 000004 00000000 00000007
W 000008 00000003 00000000
W 00000C 00000003 00000000
W 000010 00000005 00000000
W 000000 00000007 00000000
R 000000 00000000 00000000
R 000080 00000000 00000000
R 003000 00000000 00000000
W 002000 FFFFFFFF 00000000
R 002000 00000000 FFFFFFFE
W 200000 00000001 00000000
R 200000 00000000 00000001
N 000000 00000000 00000000
S 000000 0000001E 00000000
R 001000 00000000 0000001E
N 000000 00000000 00000001
R 200004 00000000 00000001
R 200004 00000000 00000004
R 200004 00000000 00000002
R 200004 00000000 00000003
R 200004 00000000 00000000
R 001000 00000000 00000000
N 000000 00000000 00000000
W 200004 00000005 00000000
W 200004 00000040 00000000
R 001000 00000000 00000000
W 200004 00000002 00000000
S 000000 0000001E 00000000
R 001000 00000000 00000004
N 000000 00000000 00000001
W 200000 0000000F 00000000
R 200000 00000000 00000007
N 000000 00000000 00000000
R 200004 00000000 00000000
W 200000 00000002 00000000
N 000000 00000000 00000001
R 200004 00000000 00000002
R 001000 00000000 00000000

//--- plic_tb.sv
`timescale 1ns/1ps

module plic_tb;

    localparam int NUM_SOURCES = 32;
    localparam int PRIO_WIDTH  = 3;
    localparam int AW          = plic_map_pkg::ADDR_WIDTH;
    localparam int DW          = plic_map_pkg::DATA_WIDTH;

    logic                   clk;
    logic                   rstn;
    logic                   req;
    logic                   wr;
    logic [AW-1:0]          addr;
    logic [DW-1:0]          wdata;
    logic [NUM_SOURCES-1:0] int_src;
    logic                   ack;
    logic [DW-1:0]          rdata;
    logic                   notif;

    int cycles      = 0;
    int cycle_limit = 100;  // Raised once the stim file is counted.

    plic_top #(
        .NUM_SOURCES(NUM_SOURCES),
        .PRIO_WIDTH(PRIO_WIDTH)
    ) i_plic_top (
        .clk(clk), .rstn(rstn), .req(req), .wr(wr), .addr(addr), .wdata(wdata),
        .int_src(int_src), .ack(ack), .rdata(rdata), .notif(notif)
    );

    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // ------------------------------
    // Run control
    // ------------------------------
    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("Checks failed");
        $fatal(1, "Simulation stopped.");
    endtask

    task automatic check_value(input string what, input logic [DW-1:0] got,
                               input logic [DW-1:0] exp);
        assert (got === exp)
        else abort_run($sformatf("FAILED at time %0t: %s is %h, expected %h",
                                 $time, what, got, exp));
    endtask

    always @(posedge clk)
    begin
        cycles <= cycles + 1;
        if (cycles >= cycle_limit)
            abort_run($sformatf("Timeout: no end of test after %0d cycles", cycle_limit));
    end

    // Full four-phase access; entered and left 1 ns after a rising edge.
    task automatic bus_access(input logic is_wr, input logic [AW-1:0] a,
                              input logic [DW-1:0] d, output logic [DW-1:0] q);
        req   = 1'b1;
        wr    = is_wr;
        addr  = a;
        wdata = d;
        do
        begin
            @(posedge clk);
            #1;
        end while (!ack);
        q   = rdata;
        req = 1'b0;
        do
        begin
            @(posedge clk);
            #1;
        end while (ack);
    endtask

    // ------------------------------
    // Stimulus
    // ------------------------------
    initial
    begin
        int            fd;
        int            lines;
        int            n;
        string         line;
        logic [7:0]    cmd;
        logic [AW-1:0] a;
        logic [DW-1:0] d;
        logic [DW-1:0] exp;
        logic [DW-1:0] got;

        req     = 1'b0;
        wr      = 1'b0;
        addr    = '0;
        wdata   = '0;
        int_src = '0;
        rstn    = 1'b0;

        fd = $fopen("plic_stim.txt", "r");
        if (fd == 0)
            abort_run("Could not open plic_stim.txt for reading");
        lines = 0;
        while ($fgets(line, fd))
            lines++;
        $fclose(fd);
        cycle_limit = 20 * lines + 100;
        fd = $fopen("plic_stim.txt", "r");
        if (fd == 0)
            abort_run("Could not reopen plic_stim.txt for reading");

        repeat (5) @(posedge clk);
        #1;
        rstn = 1'b1;

        while ($fgets(line, fd))
        begin
            if (line.len() == 0 || line.getc(0) == "#" || line.getc(0) == "\n")
                continue;
            n = $sscanf(line, "%c %h %h %h", cmd, a, d, exp);
            if (n != 4)
                abort_run($sformatf("Malformed stim line: %s", line));
            case (cmd)
                "W": bus_access(1'b1, a, d, got);
                "R":
                begin
                    bus_access(1'b0, a, '0, got);
                    check_value($sformatf("read of %h", a), got, exp);
                end
                "S":
                begin
                    int_src = d[NUM_SOURCES-1:0];
                    repeat (3) @(posedge clk);
                    #1;
                end
                "N": check_value("notif", DW'(notif), exp);
                default: abort_run($sformatf("Unknown stim command in line: %s", line));
            endcase
        end
        $fclose(fd);

        $display("All checks passed");
        $finish;
    end

endmodule

//--- plic_top.sv
`timescale 1ns/1ps

module plic_top #(
    parameter int NUM_SOURCES = plic_src_pkg::NUM_SOURCES_DEF,
    parameter int PRIO_WIDTH  = plic_src_pkg::PRIO_WIDTH_DEF,
    localparam int IDX_W = $clog2(NUM_SOURCES)
) (
    input  logic                                clk,
    input  logic                                rstn,
    input  logic                                req,
    input  logic                                wr,
    input  logic [plic_map_pkg::ADDR_WIDTH-1:0] addr,
    input  logic [plic_map_pkg::DATA_WIDTH-1:0] wdata,
    input  logic [NUM_SOURCES-1:0]              int_src,
    output logic                                ack,
    output logic [plic_map_pkg::DATA_WIDTH-1:0] rdata,
    output logic                                notif
);

    logic                                op_valid;
    plic_map_pkg::reg_op_t               op;
    logic [IDX_W-1:0]                    idx;
    logic [plic_map_pkg::DATA_WIDTH-1:0] op_wdata;
    logic                                op_done;
    logic [NUM_SOURCES-1:0]              gw_set;
    logic                                done_pulse;
    logic [IDX_W-1:0]                    done_id;
    logic [NUM_SOURCES*PRIO_WIDTH-1:0]   prio_vec;
    logic [NUM_SOURCES-1:0]              pending;
    logic [NUM_SOURCES-1:0]              enable;
    logic [PRIO_WIDTH-1:0]               threshold;
    logic [IDX_W-1:0]                    winner_id;

    plic_reg_decode #(.NUM_SOURCES(NUM_SOURCES)) i_plic_reg_decode (
        .clk(clk), .rstn(rstn), .req(req), .wr(wr), .addr(addr), .wdata(wdata),
        .op_done(op_done), .ack(ack), .op_valid(op_valid), .op(op), .idx(idx),
        .op_wdata(op_wdata)
    );

    plic_gateway #(.NUM_SOURCES(NUM_SOURCES)) i_plic_gateway (
        .clk(clk), .rstn(rstn), .int_src(int_src), .done_pulse(done_pulse),
        .done_id(done_id), .gw_set(gw_set)
    );

    plic_register_file #(
        .NUM_SOURCES(NUM_SOURCES),
        .PRIO_WIDTH(PRIO_WIDTH)
    ) i_plic_register_file (
        .clk(clk), .rstn(rstn), .op_valid(op_valid), .op(op), .idx(idx),
        .op_wdata(op_wdata), .gw_set(gw_set), .winner_id(winner_id), .op_done(op_done),
        .rdata(rdata), .done_pulse(done_pulse), .done_id(done_id), .prio_vec(prio_vec),
        .pending(pending), .enable(enable), .threshold(threshold)
    );

    plic_priority_tree #(
        .NUM_SOURCES(NUM_SOURCES),
        .PRIO_WIDTH(PRIO_WIDTH)
    ) i_plic_priority_tree (
        .clk(clk), .rstn(rstn), .prio_vec(prio_vec), .pending(pending), .enable(enable),
        .threshold(threshold), .winner_id(winner_id), .notif(notif)
    );

endmodule
